// File: msx_pkg.sv
package msx_pkg;

   // Bus and register widths
   typedef logic [7:0]         byte_t;
   typedef logic [7:0]         io_addr_t;
   typedef logic [3:0]         row_t;
   typedef logic [11:0]        period_t;
   typedef logic [3:0]         volume_t;
   typedef logic signed [15:0] sample_t;

   // Z80 I/O bus, all strobes active high
   typedef struct packed {
      io_addr_t addr;
      byte_t    dout;
      logic     rd;
      logic     wr;
      logic     iorq;
      logic     m1;
   } cpu_bus_t;

   // Per channel setup from the PSG register file
   typedef struct packed {
      period_t period;
      volume_t volume;
      logic    tone_en;
   } psg_chan_t;

   // Key event, toggle flips once per event
   typedef struct packed {
      logic       toggle;
      logic       pressed;
      row_t       row;
      logic [2:0] col;
   } key_event_t;

   // Port ranges, upper five address bits
   localparam logic [4:0] PPI_BASE = 5'(8'hA8 >> 3);
   localparam logic [4:0] PSG_BASE = 5'(8'hA0 >> 3);

   // PPI port offsets within its range
   localparam logic [1:0] PPI_PORT_A = 2'd0;
   localparam logic [1:0] PPI_PORT_B = 2'd1;
   localparam logic [1:0] PPI_PORT_C = 2'd2;

   // PSG port offsets, A0 index, A1 write, A2 read
   localparam logic [1:0] PSG_IDX = 2'd0;
   localparam logic [1:0] PSG_WR  = 2'd1;
   localparam logic [1:0] PSG_RD  = 2'd2;

   localparam int NUM_CHAN      = 3;
   localparam int KB_ROWS       = 11;
   localparam int TONE_PRESCALE = 16;

   // Mixer weights before the final shift
   localparam int CLICK_WEIGHT  = 32;
   localparam int CAS_WEIGHT    = 16;

endpackage

// File: io_bus_decode.sv
`timescale 1ns/100ps

module io_bus_decode (
   input  msx_pkg::cpu_bus_t cpu,
   input  msx_pkg::byte_t    ppi_rdata,
   input  msx_pkg::byte_t    psg_rdata,
   output logic              ppi_sel,
   output logic              psg_sel,
   output msx_pkg::byte_t    d_to_cpu,
   output logic              data_rq
);

   // I/O cycle that is not an interrupt acknowledge
   logic io_cycle;

   assign io_cycle = cpu.iorq && !cpu.m1;

   // Each device owns eight ports
   assign ppi_sel = io_cycle && (cpu.addr[7:3] == msx_pkg::PPI_BASE);
   assign psg_sel = io_cycle && (cpu.addr[7:3] == msx_pkg::PSG_BASE);

   // Only claim the bus on reads we own
   assign data_rq = cpu.rd && (ppi_sel || psg_sel);

   // Open bus reads FF
   always_comb begin
      if (data_rq && ppi_sel) begin
         d_to_cpu = ppi_rdata;
      end else if (data_rq && psg_sel) begin
         d_to_cpu = psg_rdata;
      end else begin
         d_to_cpu = 8'hFF;
      end
   end

endmodule

// File: msx_ppi.sv
`timescale 1ns/100ps

module msx_ppi (
   input  logic              clk21m,
   input  logic              exwait_n,
   input  msx_pkg::cpu_bus_t cpu,
   input  logic              ppi_sel,
   input  logic [1:0]        page,
   input  msx_pkg::byte_t    kb_data,
   output msx_pkg::byte_t    ppi_rdata,
   output logic [1:0]        slot,
   output msx_pkg::row_t     kb_row,
   output logic              keybeep,
   output logic              cas_motor
);

   // Port A holds the primary slot map, port C the misc outputs
   msx_pkg::byte_t port_a;
   msx_pkg::byte_t port_c;
   logic           map_valid;
   logic           ppi_wr;

   assign ppi_wr = ppi_sel && cpu.wr;

   // Mode 0 only, control word writes are dropped
   always_ff @(posedge clk21m or negedge exwait_n) begin
      if (!exwait_n) begin
         port_a    <= 8'h00;
         port_c    <= 8'h00;
         map_valid <= 1'b0;
      end else if (ppi_wr) begin
         map_valid <= 1'b1;
         case (cpu.addr[1:0])
            msx_pkg::PPI_PORT_A: port_a <= cpu.dout;
            msx_pkg::PPI_PORT_C: port_c <= cpu.dout;
            default: ;
         endcase
      end
   end

   // Port B is the keyboard input only
   always_comb begin
      case (cpu.addr[1:0])
         msx_pkg::PPI_PORT_A: ppi_rdata = port_a;
         msx_pkg::PPI_PORT_B: ppi_rdata = kb_data;
         msx_pkg::PPI_PORT_C: ppi_rdata = port_c;
         default:             ppi_rdata = 8'hFF;
      endcase
   end

   // Two bits per 16K page
   always_comb begin
      if (!map_valid) begin
         slot = 2'b00;
      end else begin
         case (page)
            2'd0:    slot = port_a[1:0];
            2'd1:    slot = port_a[3:2];
            2'd2:    slot = port_a[5:4];
            default: slot = port_a[7:6];
         endcase
      end
   end

   // Port C fields
   assign kb_row    = port_c[3:0];
   assign cas_motor = port_c[4];
   assign keybeep   = port_c[7];

endmodule

// File: msx_keyboard.sv
`timescale 1ns/100ps

module msx_keyboard (
   input  logic                clk21m,
   input  logic                exwait_n,
   input  msx_pkg::key_event_t key,
   input  msx_pkg::row_t       kb_row,
   output msx_pkg::byte_t      kb_data
);

   // One bit per key, high while pressed
   msx_pkg::byte_t key_mat [msx_pkg::KB_ROWS];
   logic           toggle_q;
   logic           key_new;

   // Event arrives as a flip of toggle
   assign key_new = key.toggle != toggle_q;

   always_ff @(posedge clk21m or negedge exwait_n) begin
      if (!exwait_n) begin
         toggle_q <= 1'b0;
         for (int r = 0; r < msx_pkg::KB_ROWS; r++) begin
            key_mat[r] <= 8'h00;
         end
      end else begin
         toggle_q <= key.toggle;
         // Stray rows are dropped
         if (key_new && (key.row < msx_pkg::KB_ROWS)) begin
            key_mat[key.row][key.col] <= key.pressed;
         end
      end
   end

   // Matrix reads active low, missing rows float high
   assign kb_data = (kb_row < msx_pkg::KB_ROWS) ? ~key_mat[kb_row] : 8'hFF;

   // Source must only report keys that exist in the matrix
   key_row_ok : assert property (@(posedge clk21m) disable iff (!exwait_n)
      key_new |-> (key.row < msx_pkg::KB_ROWS))
      else $error("Key event on row %0d", key.row);

endmodule

// File: psg_regs.sv
`timescale 1ns/100ps

module psg_regs (
   input  logic                                       clk21m,
   input  logic                                       exwait_n,
   input  logic                                       ce_3m58_p,
   input  msx_pkg::cpu_bus_t                          cpu,
   input  logic                                       psg_sel,
   input  logic [5:0]                                 joy0,
   input  logic [5:0]                                 joy1,
   input  logic                                       cas_audio_in,
   output msx_pkg::byte_t                             psg_rdata,
   output msx_pkg::psg_chan_t [msx_pkg::NUM_CHAN-1:0] chan,
   output logic                                       tone_tick
);

   // Register file without noise and envelope
   logic [3:0]       reg_idx;
   msx_pkg::byte_t   tone_lo [msx_pkg::NUM_CHAN];
   logic [3:0]       tone_hi [msx_pkg::NUM_CHAN];
   msx_pkg::volume_t vol     [msx_pkg::NUM_CHAN];
   msx_pkg::byte_t   mixer;
   msx_pkg::byte_t   port_b;
   msx_pkg::byte_t   port_a_in;
   msx_pkg::byte_t   reg_rd;
   logic             idx_wr;
   logic             data_wr;

   // Joystick paths
   logic [5:0] joy_a;
   logic [5:0] joy_b;
   logic [5:0] joy_a_m;
   logic [5:0] joy_b_m;

   // Tone prescaler
   logic [$clog2(msx_pkg::TONE_PRESCALE)-1:0] pre_cnt;

   assign idx_wr  = psg_sel && cpu.wr && (cpu.addr[1:0] == msx_pkg::PSG_IDX);
   assign data_wr = psg_sel && cpu.wr && (cpu.addr[1:0] == msx_pkg::PSG_WR);

   always_ff @(posedge clk21m or negedge exwait_n) begin
      if (!exwait_n) begin
         reg_idx <= 4'd0;
         mixer   <= 8'hFF;
         port_b  <= 8'h00;
         for (int i = 0; i < msx_pkg::NUM_CHAN; i++) begin
            tone_lo[i] <= 8'h00;
            tone_hi[i] <= 4'h0;
            vol[i]     <= 4'h0;
         end
      end else if (idx_wr) begin
         reg_idx <= cpu.dout[3:0];
      end else if (data_wr) begin
         // Unused upper bits are not stored
         case (reg_idx)
            4'd0:  tone_lo[0] <= cpu.dout;
            4'd1:  tone_hi[0] <= cpu.dout[3:0];
            4'd2:  tone_lo[1] <= cpu.dout;
            4'd3:  tone_hi[1] <= cpu.dout[3:0];
            4'd4:  tone_lo[2] <= cpu.dout;
            4'd5:  tone_hi[2] <= cpu.dout[3:0];
            4'd7:  mixer      <= cpu.dout;
            4'd8:  vol[0]     <= cpu.dout[3:0];
            4'd9:  vol[1]     <= cpu.dout[3:0];
            4'd10: vol[2]     <= cpu.dout[3:0];
            4'd15: port_b     <= cpu.dout;
            default: ;
         endcase
      end
   end

   // Active low pins in MSX joystick port bit order
   assign joy_a = port_b[4] ? 6'h3F :
                  {~joy0[5], ~joy0[4], ~joy0[0], ~joy0[1], ~joy0[2], ~joy0[3]};
   assign joy_b = port_b[5] ? 6'h3F :
                  {~joy1[5], ~joy1[4], ~joy1[0], ~joy1[1], ~joy1[2], ~joy1[3]};

   // Trigger lines also gated by port B outputs
   assign joy_a_m = joy_a & {port_b[0], port_b[1], 4'hF};
   assign joy_b_m = joy_b & {port_b[2], port_b[3], 4'hF};

   // Cassette in on bit 7, keyboard layout bit 6 tied low
   assign port_a_in = {cas_audio_in, 1'b0, port_b[6] ? joy_b_m : joy_a_m};

   always_comb begin
      case (reg_idx)
         4'd0:    reg_rd = tone_lo[0];
         4'd1:    reg_rd = {4'h0, tone_hi[0]};
         4'd2:    reg_rd = tone_lo[1];
         4'd3:    reg_rd = {4'h0, tone_hi[1]};
         4'd4:    reg_rd = tone_lo[2];
         4'd5:    reg_rd = {4'h0, tone_hi[2]};
         4'd7:    reg_rd = mixer;
         4'd8:    reg_rd = {4'h0, vol[0]};
         4'd9:    reg_rd = {4'h0, vol[1]};
         4'd10:   reg_rd = {4'h0, vol[2]};
         4'd14:   reg_rd = port_a_in;
         4'd15:   reg_rd = port_b;
         default: reg_rd = 8'h00;
      endcase
   end

   // Only offset 2 returns register data
   assign psg_rdata = (cpu.addr[1:0] == msx_pkg::PSG_RD) ? reg_rd : 8'hFF;

   // A low mixer bit enables the tone
   always_comb begin
      for (int i = 0; i < msx_pkg::NUM_CHAN; i++) begin
         chan[i].period  = {tone_hi[i], tone_lo[i]};
         chan[i].volume  = vol[i];
         chan[i].tone_en = !mixer[i];
      end
   end

   // One tick per TONE_PRESCALE clock enables
   always_ff @(posedge clk21m or negedge exwait_n) begin
      if (!exwait_n) begin
         pre_cnt   <= '0;
         tone_tick <= 1'b0;
      end else begin
         tone_tick <= 1'b0;
         if (ce_3m58_p) begin
            if (pre_cnt == msx_pkg::TONE_PRESCALE - 1) begin
               pre_cnt   <= '0;
               tone_tick <= 1'b1;
            end else begin
               pre_cnt <= pre_cnt + 1'b1;
            end
         end
      end
   end

   // A PSG access never reads and writes in one cycle
   rd_wr_excl : assert property (@(posedge clk21m) disable iff (!exwait_n)
      psg_sel |-> !(cpu.rd && cpu.wr))
      else $error("PSG access with rd and wr both high, addr %h", cpu.addr);

endmodule

// File: psg_tone.sv
`timescale 1ns/100ps

module psg_tone (
   input  logic               clk21m,
   input  logic               exwait_n,
   input  logic               tone_tick,
   input  msx_pkg::psg_chan_t cfg,
   output logic               chan_out
);

   msx_pkg::period_t cnt;
   logic             square;

   // Half period in prescaled ticks
   always_ff @(posedge clk21m or negedge exwait_n) begin
      if (!exwait_n) begin
         cnt    <= '0;
         square <= 1'b0;
      end else if (tone_tick) begin
         // >= so a shorter new period takes effect at once
         if (cnt >= cfg.period) begin
            cnt    <= '0;
            square <= !square;
         end else begin
            cnt <= cnt + 1'b1;
         end
      end
   end

   // Disabled tone leaves the channel at full volume
   assign chan_out = !cfg.tone_en || square;

endmodule

// File: audio_mix.sv
`timescale 1ns/100ps

module audio_mix (
   input  logic                                       clk21m,
   input  logic                                       exwait_n,
   input  logic [msx_pkg::NUM_CHAN-1:0]               chan_out,
   input  msx_pkg::psg_chan_t [msx_pkg::NUM_CHAN-1:0] chan,
   input  logic                                       keybeep,
   input  logic                                       cas_motor,
   input  logic                                       cas_audio_in,
   input  msx_pkg::sample_t                           cart_sound,
   output msx_pkg::sample_t                           audio
);

   // Weighted sum of the internal sources before the shift
   logic [11:0]        mix_sum;
   logic signed [17:0] total;

   always_comb begin
      mix_sum = '0;
      for (int i = 0; i < msx_pkg::NUM_CHAN; i++) begin
         if (chan_out[i]) begin
            mix_sum = mix_sum + 12'({chan[i].volume, 4'h0});
         end
      end
      if (keybeep) begin
         mix_sum = mix_sum + 12'(msx_pkg::CLICK_WEIGHT);
      end
      if (cas_audio_in && !cas_motor) begin
         mix_sum = mix_sum + 12'(msx_pkg::CAS_WEIGHT);
      end
      total = 18'(signed'(cart_sound)) + 18'(signed'({2'b00, mix_sum, 4'h0}));
   end

   // Saturate to the sample range
   always_ff @(posedge clk21m or negedge exwait_n) begin
      if (!exwait_n) begin
         audio <= '0;
      end else if (total > 18'sd32767) begin
         audio <= 16'sh7FFF;
      end else if (total < -18'sd32768) begin
         audio <= 16'sh8000;
      end else begin
         audio <= total[15:0];
      end
   end

endmodule

// File: msx_io.sv
`timescale 1ns/100ps

module msx_io (
   input  logic                clk21m,
   input  logic                exwait_n,
   input  logic                ce_3m58_p,
   input  msx_pkg::cpu_bus_t   cpu,
   input  logic [1:0]          page,
   input  msx_pkg::key_event_t key,
   input  logic [5:0]          joy0,
   input  logic [5:0]          joy1,
   input  msx_pkg::sample_t    cart_sound,
   input  logic                cas_audio_in,
   output msx_pkg::byte_t      d_to_cpu,
   output logic                data_rq,
   output logic [1:0]          slot,
   output logic                cas_motor,
   output msx_pkg::sample_t    audio
);

   // Device selects
   logic ppi_sel;
   logic psg_sel;

   // Read data from each device
   msx_pkg::byte_t ppi_rdata;
   msx_pkg::byte_t psg_rdata;

   // PPI to keyboard and mixer
   msx_pkg::row_t  kb_row;
   msx_pkg::byte_t kb_data;
   logic           keybeep;

   // PSG channels
   msx_pkg::psg_chan_t [msx_pkg::NUM_CHAN-1:0] chan;
   logic [msx_pkg::NUM_CHAN-1:0]               chan_out;
   logic                                       tone_tick;

   io_bus_decode u_decode (
      .cpu       (cpu),
      .ppi_rdata (ppi_rdata),
      .psg_rdata (psg_rdata),
      .ppi_sel   (ppi_sel),
      .psg_sel   (psg_sel),
      .d_to_cpu  (d_to_cpu),
      .data_rq   (data_rq)
   );

   msx_ppi u_ppi (
      .clk21m    (clk21m),
      .exwait_n  (exwait_n),
      .cpu       (cpu),
      .ppi_sel   (ppi_sel),
      .page      (page),
      .kb_data   (kb_data),
      .ppi_rdata (ppi_rdata),
      .slot      (slot),
      .kb_row    (kb_row),
      .keybeep   (keybeep),
      .cas_motor (cas_motor)
   );

   msx_keyboard u_keyboard (
      .clk21m   (clk21m),
      .exwait_n (exwait_n),
      .key      (key),
      .kb_row   (kb_row),
      .kb_data  (kb_data)
   );

   psg_regs u_psg_regs (
      .clk21m       (clk21m),
      .exwait_n     (exwait_n),
      .ce_3m58_p    (ce_3m58_p),
      .cpu          (cpu),
      .psg_sel      (psg_sel),
      .joy0         (joy0),
      .joy1         (joy1),
      .cas_audio_in (cas_audio_in),
      .psg_rdata    (psg_rdata),
      .chan         (chan),
      .tone_tick    (tone_tick)
   );

   // One tone generator per channel
   for (genvar i = 0; i < msx_pkg::NUM_CHAN; i++) begin : g_tone
      psg_tone u_tone (
         .clk21m    (clk21m),
         .exwait_n  (exwait_n),
         .tone_tick (tone_tick),
         .cfg       (chan[i]),
         .chan_out  (chan_out[i])
      );
   end

   audio_mix u_mix (
      .clk21m       (clk21m),
      .exwait_n     (exwait_n),
      .chan_out     (chan_out),
      .chan         (chan),
      .keybeep      (keybeep),
      .cas_motor    (cas_motor),
      .cas_audio_in (cas_audio_in),
      .cart_sound   (cart_sound),
      .audio        (audio)
   );

endmodule

// File: tb_msx_io_table.svh
// Columns: op, random data, port or PSG register, data, expected value or mask
// SET ports: 1 cart_sound, 2 cas_audio_in, 3 joy0, 4 joy1
task automatic load_steps();
   // Reset state
   add_step(OP_SLOTS, 1'b0, 8'h00, 16'h0000, 16'h0000);
   add_step(OP_PSGR,  1'b0, 8'h07, 16'h0000, 16'h00FF);
   add_step(OP_RD,    1'b0, 8'h98, 16'h0000, 16'h00FF);
   // Primary slot map from a random port A byte
   add_step(OP_WR,    1'b1, 8'hA8, 16'h0000, 16'h0000);
   add_step(OP_SLOTS, 1'b1, 8'h00, 16'h0000, 16'h0000);
   add_step(OP_RD,    1'b1, 8'hA8, 16'h0000, 16'h00FF);
   // Keys in row 2, columns 5 and 0
   add_step(OP_KEY,   1'b0, 8'h00, 16'h0095, 16'h0000);
   add_step(OP_KEY,   1'b0, 8'h00, 16'h0090, 16'h0000);
   add_step(OP_WR,    1'b0, 8'hAA, 16'h0002, 16'h0000);
   add_step(OP_RD,    1'b0, 8'hA9, 16'h0000, 16'h00DE);
   // Release column 5
   add_step(OP_KEY,   1'b0, 8'h00, 16'h0015, 16'h0000);
   add_step(OP_RD,    1'b0, 8'hA9, 16'h0000, 16'h00FE);
   // Empty row 5 with motor on
   add_step(OP_WR,    1'b0, 8'hAA, 16'h0015, 16'h0000);
   add_step(OP_MOTOR, 1'b0, 8'h00, 16'h0000, 16'h0001);
   add_step(OP_RD,    1'b0, 8'hA9, 16'h0000, 16'h00FF);
   // R0 to R10 random round trip
   add_step(OP_REGS,  1'b0, 8'h00, 16'h0000, 16'h0000);
   // Tone A alone at full volume
   add_step(OP_PSGW,  1'b0, 8'h09, 16'h0000, 16'h0000);
   add_step(OP_PSGW,  1'b0, 8'h0A, 16'h0000, 16'h0000);
   add_step(OP_PSGW,  1'b0, 8'h00, 16'h0004, 16'h0000);
   add_step(OP_PSGW,  1'b0, 8'h01, 16'h0000, 16'h0000);
   add_step(OP_PSGW,  1'b0, 8'h08, 16'h000F, 16'h0000);
   add_step(OP_PSGW,  1'b0, 8'h07, 16'h00FE, 16'h0000);
   add_step(OP_AUDIO, 1'b0, 8'h00, 16'h0000, 16'h0F00);
   add_step(OP_AUDIO, 1'b0, 8'h00, 16'h0000, 16'h0000);
   add_step(OP_AUDIO, 1'b0, 8'h00, 16'h0000, 16'h0F00);
   add_step(OP_PSGW,  1'b0, 8'h07, 16'h00FF, 16'h0000);
   // Silent PSG, most negative cartridge sample
   add_step(OP_PSGW,  1'b0, 8'h08, 16'h0000, 16'h0000);
   add_step(OP_SET,   1'b0, 8'h01, 16'h8000, 16'h0000);
   add_step(OP_AUDIO, 1'b0, 8'h00, 16'h0000, 16'h8000);
   // Volumes 3, 5, 2 give a PSG sum of 160
   add_step(OP_PSGW,  1'b0, 8'h08, 16'h0003, 16'h0000);
   add_step(OP_PSGW,  1'b0, 8'h09, 16'h0005, 16'h0000);
   add_step(OP_PSGW,  1'b0, 8'h0A, 16'h0002, 16'h0000);
   add_step(OP_AUDIO, 1'b0, 8'h00, 16'h0000, 16'h8A00);
   // Key click adds 32
   add_step(OP_WR,    1'b0, 8'hAA, 16'h0080, 16'h0000);
   add_step(OP_AUDIO, 1'b0, 8'h00, 16'h0000, 16'h8C00);
   // Cassette adds 16 only with the motor off
   add_step(OP_SET,   1'b0, 8'h02, 16'h0001, 16'h0000);
   add_step(OP_AUDIO, 1'b0, 8'h00, 16'h0000, 16'h8D00);
   add_step(OP_WR,    1'b0, 8'hAA, 16'h0090, 16'h0000);
   add_step(OP_AUDIO, 1'b0, 8'h00, 16'h0000, 16'h8C00);
   // Positive overflow
   add_step(OP_SET,   1'b0, 8'h01, 16'h7F00, 16'h0000);
   add_step(OP_AUDIO, 1'b0, 8'h00, 16'h0000, 16'h7FFF);
   // Joystick through R14, stick chosen by R15 bit 6
   add_step(OP_SET,   1'b0, 8'h03, 16'h000B, 16'h0000);
   add_step(OP_SET,   1'b0, 8'h04, 16'h0026, 16'h0000);
   add_step(OP_PSGW,  1'b0, 8'h0F, 16'h000F, 16'h0000);
   add_step(OP_PSGR,  1'b0, 8'h0E, 16'h0000, 16'h00B2);
   add_step(OP_PSGW,  1'b0, 8'h0F, 16'h004F, 16'h0000);
   add_step(OP_PSGR,  1'b0, 8'h0E, 16'h0000, 16'h0099);
   add_step(OP_SET,   1'b0, 8'h02, 16'h0000, 16'h0000);
   add_step(OP_PSGR,  1'b0, 8'h0E, 16'h0000, 16'h0019);
endtask

// File: tb_msx_io.sv
`timescale 1ns/100ps

module tb_msx_io;

   // Step operations
   localparam logic [3:0] OP_WR    = 4'd0;
   localparam logic [3:0] OP_RD    = 4'd1;
   localparam logic [3:0] OP_KEY   = 4'd2;
   localparam logic [3:0] OP_SET   = 4'd3;
   localparam logic [3:0] OP_SLOTS = 4'd4;
   localparam logic [3:0] OP_MOTOR = 4'd5;
   localparam logic [3:0] OP_PSGW  = 4'd6;
   localparam logic [3:0] OP_PSGR  = 4'd7;
   localparam logic [3:0] OP_REGS  = 4'd8;
   localparam logic [3:0] OP_AUDIO = 4'd9;

   // Slowest tone half period is 5 ticks of 96 clocks
   localparam int AUDIO_TIMEOUT = 1500;

   typedef struct packed {
      logic [3:0]  op;
      logic        rnd;
      logic [7:0]  port;
      logic [15:0] data;
      logic [15:0] exp;
   } step_t;

   logic                clk21m;
   logic                exwait_n;
   logic                ce_3m58_p;
   msx_pkg::cpu_bus_t   cpu;
   logic [1:0]          page;
   msx_pkg::key_event_t key;
   logic [5:0]          joy0;
   logic [5:0]          joy1;
   msx_pkg::sample_t    cart_sound;
   logic                cas_audio_in;
   msx_pkg::byte_t      d_to_cpu;
   logic                data_rq;
   logic [1:0]          slot;
   logic                cas_motor;
   msx_pkg::sample_t    audio;

   step_t          steps [$];
   integer         seed;
   msx_pkg::byte_t last_rand;
   logic [2:0]     ce_cnt;

   msx_io i_dut (
      .clk21m       (clk21m),
      .exwait_n     (exwait_n),
      .ce_3m58_p    (ce_3m58_p),
      .cpu          (cpu),
      .page         (page),
      .key          (key),
      .joy0         (joy0),
      .joy1         (joy1),
      .cart_sound   (cart_sound),
      .cas_audio_in (cas_audio_in),
      .d_to_cpu     (d_to_cpu),
      .data_rq      (data_rq),
      .slot         (slot),
      .cas_motor    (cas_motor),
      .audio        (audio)
   );

   initial begin
      clk21m = 1'b0;
      forever #50 clk21m = ~clk21m;
   end

   // 3.58 MHz enable, one clock in six
   always @(posedge clk21m) begin
      ce_cnt    <= (ce_cnt == 3'd5) ? 3'd0 : ce_cnt + 3'd1;
      ce_3m58_p <= (ce_cnt == 3'd5);
   end

   task automatic abort_run();
      $display("Test failed");
      $fatal(1);
   endtask

   task automatic check_val(input string name, input logic [15:0] got,
                            input logic [15:0] exp);
      assert (got === exp)
         else begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            abort_run();
         end
   endtask

   task automatic add_step(input logic [3:0] op, input logic rnd, input logic [7:0] port,
                           input logic [15:0] data, input logic [15:0] exp);
      steps.push_back({op, rnd, port, data, exp});
   endtask

   // PPI at A8 to AF, PSG at A0 to A7
   function automatic logic claimed(input logic [7:0] port);
      return (port[7:3] == 5'h15) || (port[7:3] == 5'h14);
   endfunction

   // Stored bits per PSG register, R6 noise is not kept
   function automatic logic [7:0] reg_mask(input int r);
      case (r)
         1, 3, 5, 8, 9, 10: return 8'h0F;
         6:                 return 8'h00;
         default:           return 8'hFF;
      endcase
   endfunction

   task automatic io_write(input logic [7:0] port, input logic [7:0] data);
      @(posedge clk21m);
      cpu.addr <= port;
      cpu.dout <= data;
      cpu.wr   <= 1'b1;
      cpu.iorq <= 1'b1;
      @(posedge clk21m);
      cpu.wr   <= 1'b0;
      cpu.iorq <= 1'b0;
   endtask

   // Sampled mid cycle while the read is held
   task automatic io_read(input logic [7:0] port, output logic [7:0] data, output logic rq);
      @(posedge clk21m);
      cpu.addr <= port;
      cpu.rd   <= 1'b1;
      cpu.iorq <= 1'b1;
      @(negedge clk21m);
      data = d_to_cpu;
      rq   = data_rq;
      @(posedge clk21m);
      cpu.rd   <= 1'b0;
      cpu.iorq <= 1'b0;
   endtask

   task automatic wait_audio(input logic [15:0] exp);
      int n;
      n = 0;
      @(negedge clk21m);
      while (audio !== exp && n < AUDIO_TIMEOUT) begin
         @(negedge clk21m);
         n++;
      end
      assert (audio === exp)
         else begin
            $display("Timeout waiting for audio %h, still at %h", exp, audio);
            abort_run();
         end
   endtask

   task automatic run_step(input step_t s);
      logic [7:0]  rdata;
      logic [7:0]  wdata;
      logic        rq;
      logic [15:0] exp;
      case (s.op)
         OP_WR: begin
            if (s.rnd) begin
               last_rand = 8'($random(seed));
               wdata = last_rand;
            end else begin
               wdata = s.data[7:0];
            end
            io_write(s.port, wdata);
         end
         OP_RD: begin
            io_read(s.port, rdata, rq);
            exp = s.rnd ? ({8'h00, last_rand} & s.exp) : s.exp;
            check_val("d_to_cpu", rdata, exp);
            check_val("data_rq", rq, claimed(s.port));
         end
         OP_KEY: begin
            // Data holds pressed, row and column
            @(posedge clk21m);
            key.toggle  <= ~key.toggle;
            key.pressed <= s.data[7];
            key.row     <= s.data[6:3];
            key.col     <= s.data[2:0];
            @(posedge clk21m);
         end
         OP_SET: begin
            @(posedge clk21m);
            case (s.port)
               8'd1:    cart_sound <= s.data;
               8'd2:    cas_audio_in <= s.data[0];
               8'd3:    joy0 <= s.data[5:0];
               default: joy1 <= s.data[5:0];
            endcase
         end
         OP_SLOTS: begin
            for (int p = 0; p < 4; p++) begin
               @(posedge clk21m);
               page <= p[1:0];
               @(negedge clk21m);
               exp = s.rnd ? {14'h0, last_rand[2*p +: 2]} : s.exp;
               check_val("slot", slot, exp);
            end
         end
         OP_MOTOR: begin
            @(negedge clk21m);
            check_val("cas_motor", cas_motor, s.exp);
         end
         OP_PSGW: begin
            io_write(8'hA0, s.port);
            io_write(8'hA1, s.data[7:0]);
         end
         OP_PSGR: begin
            io_write(8'hA0, s.port);
            io_read(8'hA2, rdata, rq);
            check_val("d_to_cpu", rdata, s.exp);
         end
         OP_REGS: begin
            for (int r = 0; r <= 10; r++) begin
               wdata = 8'($random(seed));
               io_write(8'hA0, 8'(r));
               io_write(8'hA1, wdata);
               io_read(8'hA2, rdata, rq);
               check_val("d_to_cpu", rdata, wdata & reg_mask(r));
            end
         end
         default: begin
            wait_audio(s.exp);
         end
      endcase
   endtask

   `include "tb_msx_io_table.svh"

   initial begin
      seed         = 32'haef92243;
      last_rand    = 8'h00;
      ce_cnt       = 3'd0;
      ce_3m58_p    = 1'b0;
      exwait_n     = 1'b0;
      cpu          = '0;
      page         = 2'd0;
      key          = '0;
      joy0         = 6'h00;
      joy1         = 6'h00;
      cart_sound   = 16'sh0000;
      cas_audio_in = 1'b0;
      load_steps();
      repeat (5) @(posedge clk21m);
      exwait_n <= 1'b1;
      foreach (steps[i]) begin
         run_step(steps[i]);
      end
      $display("Test passed");
      $finish;
   end

endmodule

// File: build.f
msx_pkg.sv
io_bus_decode.sv
msx_ppi.sv
msx_keyboard.sv
psg_regs.sv
psg_tone.sv
audio_mix.sv
msx_io.sv
+incdir+.
tb_msx_io.sv
